//--- rtl/div_pkg.sv
`default_nettype none

package div_pkg;

  typedef logic [15:0] dividend_t;
  typedef logic [7:0]  divisor_t;
  typedef logic [7:0]  quotient_t;
  typedef logic [7:0]  remainder_t;

  // Result classification, carried with every response.
  typedef enum logic [1:0] {
    DIV_OK       = 2'd0,
    DIV_ZERO     = 2'd1,
    DIV_OVERFLOW = 2'd2  // Quotient would need more than 8 bits.
  } div_status_e;

  typedef struct packed {
    dividend_t dividend;
    divisor_t  divisor;
  } div_req_t;

  typedef struct packed {
    quotient_t   quotient;
    remainder_t  remainder;
    div_status_e status;
  } div_rsp_t;

endpackage

`default_nettype wire

//--- rtl/div_cell.sv
`default_nettype none
`timescale 1ns/1ns

module div_cell #(
  parameter bit APPROX = 1'b0
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  assign bout = (~x & y) | (~(x ^ y) & bin); // Full-subtractor borrow in both variants.

  if (APPROX) begin : g_approx
    // Difference is forced high except for 000 and 110, so 011 and 101 come out wrong.
    assign diff = ~((~x & ~y & ~bin) | (x & y & ~bin));
  end else begin : g_exact
    assign diff = x ^ y ^ bin;
  end

  assign r_sub = qs ? diff : x; // Restore the minuend when the row does not subtract.

endmodule

`default_nettype wire

//--- rtl/div_array.sv
`default_nettype none
`timescale 1ns/1ns

module div_array #(
  parameter int APPROX_DEPTH = 4
) (
  input  div_pkg::dividend_t  dividend,
  input  div_pkg::divisor_t   divisor,
  output div_pkg::quotient_t  quotient,
  output div_pkg::remainder_t remainder
);

  logic [7:0] x_row   [8]; // Minuend bits entering each row.
  logic [7:0] bin_row [8];
  logic [7:0] r_row   [8];
  logic [7:0] b_row   [8];
  logic [7:0] top_bit;

  for (genvar i = 0; i < 8; i++) begin : g_row
    // The top row reads the dividend directly, lower rows shift in one new dividend bit
    // below the partial remainder of the row above.
    if (i == 7) begin : g_top
      assign x_row[i]   = dividend[14:7];
      assign top_bit[i] = dividend[15];
    end else begin : g_lower
      assign x_row[i]   = {r_row[i+1][6:0], dividend[i]};
      assign top_bit[i] = r_row[i+1][7];
    end

    assign bin_row[i] = {b_row[i][6:0], 1'b0};

    for (genvar j = 0; j < 8; j++) begin : g_col
      div_cell #(
        .APPROX (i + j < APPROX_DEPTH)
      ) u_cell (
        .x     (x_row[i][j]),
        .y     (divisor[j]),
        .bin   (bin_row[i][j]),
        .qs    (quotient[i]),
        .r_sub (r_row[i][j]),
        .bout  (b_row[i][j])
      );
    end

    // The row subtracts when the bit shifted out is set or no borrow is left.
    assign quotient[i] = top_bit[i] | ~b_row[i][7];
  end

  assign remainder = r_row[0];

endmodule

`default_nettype wire

//--- rtl/div_operand_stage.sv
`default_nettype none
`timescale 1ns/1ns

module div_operand_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_op,
  input  div_pkg::div_req_t   req,
  output div_pkg::div_req_t   req_q,
  output div_pkg::div_status_e status_q
);

  div_pkg::div_status_e status_d;
  div_pkg::divisor_t    upper_byte;

  assign upper_byte = req.dividend[15:8];

  always_comb begin
    if (req.divisor == '0) begin
      status_d = div_pkg::DIV_ZERO;
    end else if (upper_byte >= req.divisor) begin
      // A quotient of 256 or more cannot be returned in 8 bits.
      status_d = div_pkg::DIV_OVERFLOW;
    end else begin
      status_d = div_pkg::DIV_OK;
    end
  end

  always_ff @(posedge clk) begin
    if (load_op) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      status_q <= div_pkg::DIV_OK;
    end else if (load_op) begin
      status_q <= status_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/div_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic out_ready,
  output logic in_ready,
  output logic out_valid,
  output logic load_op,
  output logic load_res
);

  logic full1;
  logic full2;

  // Stage 1 moves on when stage 2 is free or hands its result off in this cycle.
  assign load_res  = full1 & (~full2 | out_ready);
  assign in_ready  = ~full1 | load_res;
  assign load_op   = in_valid & in_ready;
  assign out_valid = full2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full1 <= 1'b0;
      full2 <= 1'b0;
    end else begin
      full1 <= load_op | (full1 & ~load_res);
      full2 <= load_res | (full2 & ~out_ready); // Holds under a stall.
    end
  end

endmodule

`default_nettype wire

//--- rtl/div_result_stage.sv
`default_nettype none
`timescale 1ns/1ns

module div_result_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_res,
  input  div_pkg::quotient_t   quotient,
  input  div_pkg::remainder_t  remainder,
  input  div_pkg::div_status_e status,
  output div_pkg::div_rsp_t    rsp
);

  div_pkg::quotient_t   quotient_d;
  div_pkg::remainder_t  remainder_d;
  div_pkg::quotient_t   quotient_q;
  div_pkg::remainder_t  remainder_q;
  div_pkg::div_status_e status_q;

  // Error cases replace the array output with fixed saturation values.
  always_comb begin
    case (status)
      div_pkg::DIV_ZERO: begin
        quotient_d  = 8'hFF;
        remainder_d = 8'h00;
      end
      div_pkg::DIV_OVERFLOW: begin
        quotient_d  = 8'hFF;
        remainder_d = 8'hFF;
      end
      default: begin
        quotient_d  = quotient;
        remainder_d = remainder;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (load_res) begin
      quotient_q  <= quotient_d;
      remainder_q <= remainder_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      status_q <= div_pkg::DIV_OK;
    end else if (load_res) begin
      status_q <= status;
    end
  end

  assign rsp = '{quotient: quotient_q, remainder: remainder_q, status: status_q};

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
`default_nettype none
`timescale 1ns/1ns

module div_unit #(
  parameter int APPROX_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic              out_ready,
  input  div_pkg::div_req_t req,
  output logic              in_ready,
  output logic              out_valid,
  output div_pkg::div_rsp_t rsp
);

  logic                 load_op;
  logic                 load_res;
  div_pkg::div_req_t    req_q;
  div_pkg::div_status_e status_q;
  div_pkg::quotient_t   raw_quotient;
  div_pkg::remainder_t  raw_remainder;

  div_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .load_op   (load_op),
    .load_res  (load_res)
  );

  div_operand_stage u_operand_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_op  (load_op),
    .req      (req),
    .req_q    (req_q),
    .status_q (status_q)
  );

  // The array settles between the two registers.
  div_array #(
    .APPROX_DEPTH (APPROX_DEPTH)
  ) u_array (
    .dividend  (req_q.dividend),
    .divisor   (req_q.divisor),
    .quotient  (raw_quotient),
    .remainder (raw_remainder)
  );

  div_result_stage u_result_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_res  (load_res),
    .quotient  (raw_quotient),
    .remainder (raw_remainder),
    .status    (status_q),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

//--- sim/div_unit_sva.sv
`default_nettype none
`timescale 1ns/1ns

module div_unit_sva (
  input logic              clk,
  input logic              rst_n,
  input logic              in_ready,
  input logic              out_valid,
  input logic              out_ready,
  input div_pkg::div_rsp_t rsp
);

  // A stalled response keeps its value until the consumer takes it.
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(rsp))
    else $error("rsp or out_valid changed while the output was stalled");

  assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high after a reset edge");

  assert property (@(posedge clk) !rst_n |=> in_ready)
    else $error("in_ready low after a reset edge");

  // An empty stage 1 always takes input, so in_ready only drops behind a full, stalled pipe.
  assert property (@(posedge clk) disable iff (!rst_n)
    !in_ready |-> out_valid && !out_ready)
    else $error("in_ready low while stage 1 could still take a request");

endmodule

bind div_unit div_unit_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .rsp       (rsp)
);

`default_nettype wire

//--- sim/tb_div_unit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_div_unit;

  localparam int N_VECTORS      = 20;
  localparam int TIMEOUT_CYCLES = 20 * N_VECTORS;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              out_ready;
  logic              in_ready;
  logic              out_valid;
  div_pkg::div_req_t req;
  div_pkg::div_rsp_t rsp;

  logic [15:0]       trace_mem [N_VECTORS*5]; // Five columns per vector.
  div_pkg::div_rsp_t expected_q [$];
  int                vector_q [$];           // Trace index of each expected response.
  int                cycle_count;

  div_unit #(
    .APPROX_DEPTH (4)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .req       (req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout: %0d cycles passed before all responses arrived.", cycle_count);
        abort_run();
      end
    end
  end

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic div_pkg::div_req_t trace_request(input int idx);
    div_pkg::div_req_t r;
    r.dividend = trace_mem[5*idx];
    r.divisor  = trace_mem[5*idx+1][7:0];
    return r;
  endfunction

  function automatic div_pkg::div_rsp_t trace_response(input int idx);
    div_pkg::div_rsp_t r;
    r.quotient  = trace_mem[5*idx+2][7:0];
    r.remainder = trace_mem[5*idx+3][7:0];
    r.status    = div_pkg::div_status_e'(trace_mem[5*idx+4][1:0]);
    return r;
  endfunction

  task automatic check_quotient(input string test_name, input div_pkg::quotient_t expected,
                                input div_pkg::quotient_t actual);
    if (actual !== expected) begin
      $display("error %s: quotient expected %h, actual %h", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_remainder(input string test_name, input div_pkg::remainder_t expected,
                                 input div_pkg::remainder_t actual);
    if (actual !== expected) begin
      $display("error %s: remainder expected %h, actual %h", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_status(input string test_name, input div_pkg::div_status_e expected,
                              input div_pkg::div_status_e actual);
    if (actual !== expected) begin
      $display("error %s: status expected %s, actual %s", test_name, expected.name(),
               actual.name());
      abort_run();
    end
  endtask

  task automatic expect_flag(input string test_name, input string flag_name,
                             input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s: %s expected %b, actual %b", test_name, flag_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic verify_response(input string test_name, input div_pkg::div_rsp_t expected,
                                 input div_pkg::div_rsp_t actual);
    check_quotient(test_name, expected.quotient, actual.quotient);
    check_remainder(test_name, expected.remainder, actual.remainder);
    check_status(test_name, expected.status, actual.status);
  endtask

  initial begin
    int next_idx;
    int n_checked;
    bit holding;
    div_pkg::div_rsp_t exp_rsp;
    void'($urandom(32'ha5f314e5));
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    req        = '0;
    next_idx   = 0;
    n_checked  = 0;
    holding    = 1'b0;
    $readmemh("sim/div_trace.txt", trace_mem);
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    expect_flag("reset", "out_valid", 1'b0, out_valid);
    expect_flag("reset", "in_ready", 1'b1, in_ready);

    // A lone request with out_ready high is taken by the consumer two edges after acceptance.
    req       = trace_request(0);
    in_valid  = 1'b1;
    out_ready = 1'b1;
    @(posedge clk);
    #1 in_valid = 1'b0;
    expect_flag("latency", "out_valid one edge after accept", 1'b0, out_valid);
    @(posedge clk);
    #1;
    expect_flag("latency", "out_valid two edges after accept", 1'b1, out_valid);
    verify_response("latency", trace_response(0), rsp);
    @(posedge clk);
    #1;
    expect_flag("latency", "out_valid after the transfer", 1'b0, out_valid);

    // Whole trace with random input gaps and output stalls. Handshakes are sampled mid-cycle.
    while (n_checked < N_VECTORS) begin
      if (!holding) begin
        if (next_idx < N_VECTORS && $urandom % 4 != 0) begin
          req      = trace_request(next_idx);
          in_valid = 1'b1;
        end else begin
          in_valid = 1'b0;
        end
      end
      out_ready = ($urandom % 3 != 0);
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          $display("A response came out with no request waiting for it.");
          abort_run();
        end
        exp_rsp = expected_q.pop_front();
        verify_response($sformatf("vector %0d", vector_q.pop_front()), exp_rsp, rsp);
        n_checked++;
      end
      if (in_valid && in_ready) begin
        expected_q.push_back(trace_response(next_idx));
        vector_q.push_back(next_idx);
        next_idx++;
      end
      holding = in_valid && !in_ready; // The request stays on the bus until it is taken.
      @(posedge clk);
      #1;
    end

    // Once every request is answered the pipe must stay empty.
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (3) begin
      @(negedge clk);
      expect_flag("drain", "out_valid", 1'b0, out_valid);
      expect_flag("drain", "in_ready", 1'b1, in_ready);
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/div_trace.txt
// Columns in hex: dividend divisor quotient remainder status
// Status 0 is ok, 1 is divide by zero, 2 is overflow.
1234 40 48 34 0
7fff 80 ff 7f 0
00c8 10 0c 08 0
5a00 f0 60 00 0
0000 01 00 00 0
0c80 19 80 00 0
0007 03 02 01 0
efff f0 ff ef 0
0f0f 10 f0 0f 0
3039 80 60 39 0
0005 03 01 06 0
0010 03 07 0f 0
0011 03 07 0c 0
1234 00 ff 00 1
0000 00 ff 00 1
1200 12 ff ff 2
ffff 80 ff ff 2
8000 01 ff ff 2
00ff 00 ff 00 1
0100 01 ff ff 2

//--- compile.f
rtl/div_pkg.sv
rtl/div_cell.sv
rtl/div_array.sv
rtl/div_operand_stage.sv
rtl/div_ctrl.sv
rtl/div_result_stage.sv
rtl/div_unit.sv
sim/div_unit_sva.sv
sim/tb_div_unit.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_div_unit
RTL_TOP    ?= div_unit
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= No errors
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
